//--- common/tx_pkg.sv
// ******************************
// transmit path shared package
// holds the frame source select type
// and the bounds shared by the frame
// interface and the pattern stage
// ******************************

package tx_pkg;

  // ******************************
  // widths and bounds
  // ******************************

  // bits needed to encode the frame source
  localparam int unsigned pattern_sel_w = 2;

  // largest frame the serializer path is built for
  localparam int unsigned max_serdes_factor = 8;

  // ******************************
  // frame source select
  // ******************************

  // pat_data passes packed input samples on
  // pat_ramp replaces the frame with an incrementing ramp
  // pat_const replaces every sample with one fixed word
  typedef enum logic [pattern_sel_w-1:0] {
    pat_data  = 2'd0,
    pat_ramp  = 2'd1,
    pat_const = 2'd2
  } pattern_sel_t;

endpackage

//--- common/tx_frame_if.sv
// ******************************
// frame interface
// one frame of samples, its load
// strobe and the idle marker
// ******************************

`timescale 1ns/100ps

interface tx_frame_if #(
  parameter int data_width    = 16,
  parameter int serdes_factor = 8
) ();

  import tx_pkg::*;

  // sample 0 is the first one on the lanes
  logic [data_width-1:0] samples [serdes_factor];
  // one cycle strobe, samples and idle valid here
  logic                  loaden;
  // frame carries no input data
  logic                  idle;

  // frame size has to fit the bound and split into two halves
  if (serdes_factor > max_serdes_factor || (serdes_factor % 2) != 0) begin : g_bad_factor
    $error("tx_frame_if: serdes_factor %0d not supported", serdes_factor);
  end

  // producer side
  modport src (output samples, output loaden, output idle);

  // consumer side
  modport snk (input samples, input loaden, input idle);

endinterface

//--- rtl/sample_packer.sv
// ******************************
// sample packer
// gathers input samples into frames of
// serdes_factor words, runs the frame
// load timing and sends an idle frame
// when nothing complete is waiting
// ******************************

`timescale 1ns/100ps

module sample_packer #(
  parameter int data_width    = 16,
  parameter int serdes_factor = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [data_width-1:0] sample,
  input  logic                  sample_valid,
  tx_frame_if.src               frame
);

  localparam int cnt_w = (serdes_factor > 1) ? $clog2(serdes_factor) : 1;
  localparam logic [cnt_w-1:0] last_idx = cnt_w'(serdes_factor - 1);

  // ******************************
  // load timing
  // ******************************

  logic [cnt_w-1:0] phase;

  // modulo serdes_factor count, first strobe lands on
  // the serdes_factor-th cycle out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (phase == last_idx) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  assign frame.loaden = (phase == last_idx);

  // ******************************
  // collecting buffer
  // ******************************

  logic [cnt_w-1:0]      word_idx;
  logic [data_width-1:0] buffer [serdes_factor];
  logic [data_width-1:0] fill [serdes_factor];
  logic                  frame_done;

  // buffer with the incoming word dropped into its slot
  always_comb begin
    fill           = buffer;
    fill[word_idx] = sample;
  end

  assign frame_done = sample_valid && (word_idx == last_idx);

  // word position within the frame being filled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_idx <= '0;
    end else if (sample_valid) begin
      word_idx <= frame_done ? '0 : word_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      buffer <= fill;
    end
  end

  // ******************************
  // pending frame
  // ******************************

  logic [data_width-1:0] pending [serdes_factor];
  logic                  pending_vld;

  // a fresh frame overwrites one still waiting
  always_ff @(posedge clk) begin
    if (frame_done) begin
      pending <= fill;
    end
  end

  // completion wins over the load clearing the flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_vld <= 1'b0;
    end else if (frame_done) begin
      pending_vld <= 1'b1;
    end else if (frame.loaden) begin
      pending_vld <= 1'b0;
    end
  end

  // zero frame with idle set when nothing is waiting
  always_comb begin
    for (int i = 0; i < serdes_factor; i++) begin
      frame.samples[i] = pending_vld ? pending[i] : '0;
    end
    frame.idle = !pending_vld;
  end

endmodule

//--- rtl/tx_pattern_gen.sv
// ******************************
// test pattern stage
// picks data, ramp or constant frames
// per frame and keeps the ramp state
// ******************************

`timescale 1ns/100ps

module tx_pattern_gen #(
  parameter int data_width    = 16,
  parameter int serdes_factor = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  tx_pkg::pattern_sel_t  pattern_sel,
  input  logic [data_width-1:0] pattern_word,
  tx_frame_if.snk               in_frame,
  tx_frame_if.src               out_frame
);

  import tx_pkg::*;

  // ******************************
  // ramp state
  // ******************************

  // first word of the next ramp frame
  logic [data_width-1:0] ramp_base;

  // moves on by one frame of words per ramp frame
  // and wraps with the word width
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ramp_base <= '0;
    end else if (in_frame.loaden && pattern_sel == pat_ramp) begin
      ramp_base <= ramp_base + data_width'(serdes_factor);
    end
  end

  // ******************************
  // source select
  // ******************************

  // load strobe goes through untouched
  assign out_frame.loaden = in_frame.loaden;

  // select is only looked at when the strobe is up
  always_comb begin
    case (pattern_sel)
      pat_ramp: begin
        for (int i = 0; i < serdes_factor; i++) begin
          out_frame.samples[i] = ramp_base + data_width'(i);
        end
        out_frame.idle = 1'b0;
      end
      pat_const: begin
        for (int i = 0; i < serdes_factor; i++) begin
          out_frame.samples[i] = pattern_word;
        end
        out_frame.idle = 1'b0;
      end
      default: begin
        // data mode, idle marker kept
        out_frame.samples = in_frame.samples;
        out_frame.idle    = in_frame.idle;
      end
    endcase
  end

endmodule

//--- serdes_out/serdes_out_core.sv
// ******************************
// lane serializer
// loads one lane vector per frame and
// shifts it out msb first as a
// true and complement pair
// ******************************

`timescale 1ns/100ps

module serdes_out_core #(
  parameter int serdes_factor = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     loaden,
  input  logic [serdes_factor-1:0] data,
  output logic                     data_out_p,
  output logic                     data_out_n
);

  // ******************************
  // shift register
  // ******************************

  logic [serdes_factor-1:0] shift_q;

  // load on the strobe, otherwise one bit left per clock
  // zero fill behind the last bit of the frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q <= '0;
    end else if (loaden) begin
      shift_q <= data;
    end else begin
      shift_q <= shift_q << 1;
    end
  end

  // ******************************
  // output pair
  // ******************************

  // msb is the bit on the wire this cycle
  assign data_out_p = shift_q[serdes_factor-1];

  // complement leg of the pair
  assign data_out_n = ~shift_q[serdes_factor-1];

endmodule

//--- serdes_out/serdes_out.sv
// ******************************
// serializer block
// turns a frame into per lane bit
// vectors, drives the lane cores, the
// frame clock and the underflow pulse
// ******************************

`timescale 1ns/100ps

module serdes_out #(
  parameter int data_width    = 16,
  parameter int serdes_factor = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  tx_frame_if.snk               frame,
  output logic [data_width-1:0] data_out_p,
  output logic [data_width-1:0] data_out_n,
  output logic                  frame_out,
  output logic                  underflow
);

  localparam int cnt_w = (serdes_factor > 1) ? $clog2(serdes_factor) : 1;
  localparam logic [cnt_w-1:0] half_last = cnt_w'(serdes_factor / 2 - 1);

  // lane n holds bit n of every sample, sample 0 at the msb
  logic [serdes_factor-1:0] lane_data [data_width];

  for (genvar n = 0; n < data_width; n++) begin : g_lane
    for (genvar i = 0; i < serdes_factor; i++) begin : g_bit
      assign lane_data[n][serdes_factor-1-i] = frame.samples[i][n];
    end

    serdes_out_core #(
      .serdes_factor (serdes_factor)
    ) core_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .loaden     (frame.loaden),
      .data       (lane_data[n]),
      .data_out_p (data_out_p[n]),
      .data_out_n (data_out_n[n])
    );
  end

  // ******************************
  // frame clock and underflow
  // ******************************

  // index of the sample on the lanes in the current cycle
  logic [cnt_w-1:0] bit_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt   <= '0;
      frame_out <= 1'b0;
      underflow <= 1'b0;
    end else begin
      bit_cnt   <= frame.loaden ? '0 : bit_cnt + 1'b1;
      // high over the first half of the shifted samples
      if (frame.loaden) begin
        frame_out <= 1'b1;
      end else if (bit_cnt == half_last) begin
        frame_out <= 1'b0;
      end
      // one cycle pulse with the first sample of an idle frame
      underflow <= frame.loaden && frame.idle;
    end
  end

endmodule

//--- rtl/tx_top.sv
// ******************************
// lvds transmit top
// sample packer, pattern stage and
// serializer for a dac data port
// ******************************

`timescale 1ns/100ps

module tx_top #(
  parameter int data_width    = 16,
  parameter int serdes_factor = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [data_width-1:0] sample,
  input  logic                  sample_valid,
  input  tx_pkg::pattern_sel_t  pattern_sel,
  input  logic [data_width-1:0] pattern_word,
  output logic [data_width-1:0] data_out_p,
  output logic [data_width-1:0] data_out_n,
  output logic                  frame_out,
  output logic                  underflow
);

  // packer to pattern stage
  tx_frame_if #(
    .data_width    (data_width),
    .serdes_factor (serdes_factor)
  ) pack_frame ();

  // pattern stage to serializer
  tx_frame_if #(
    .data_width    (data_width),
    .serdes_factor (serdes_factor)
  ) out_frame ();

  sample_packer #(
    .data_width    (data_width),
    .serdes_factor (serdes_factor)
  ) sample_packer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .frame        (pack_frame.src)
  );

  tx_pattern_gen #(
    .data_width    (data_width),
    .serdes_factor (serdes_factor)
  ) tx_pattern_gen_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pattern_sel  (pattern_sel),
    .pattern_word (pattern_word),
    .in_frame     (pack_frame.snk),
    .out_frame    (out_frame.src)
  );

  serdes_out #(
    .data_width    (data_width),
    .serdes_factor (serdes_factor)
  ) serdes_out_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame      (out_frame.snk),
    .data_out_p (data_out_p),
    .data_out_n (data_out_n),
    .frame_out  (frame_out),
    .underflow  (underflow)
  );

endmodule

//--- dv/tx_asserts.sv
// ******************************
// transmit path assertions
// load strobe rhythm, underflow
// framing and output reset values
// ******************************

`timescale 1ns/100ps

module tx_asserts #(
  parameter int data_width    = 16,
  parameter int serdes_factor = 8
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  loaden,
  input logic [data_width-1:0] data_out_p,
  input logic [data_width-1:0] data_out_n,
  input logic                  frame_out,
  input logic                  underflow
);

  // strobe comes back after exactly one frame
  a_loaden_next: assert property (@(posedge clk) disable iff (!rst_n)
    loaden |-> ##serdes_factor loaden)
    else $error("loaden did not recur after %0d cycles", serdes_factor);

  // and stays low in between
  a_loaden_gap: assert property (@(posedge clk) disable iff (!rst_n)
    loaden |=> !loaden [*(serdes_factor-1)])
    else $error("loaden came back early");

  // underflow marks the first cycle of a frame
  a_underflow_frame: assert property (@(posedge clk) disable iff (!rst_n)
    underflow |-> frame_out)
    else $error("underflow high while frame_out low");

  // every output sits at its reset value behind a reset edge
  a_reset_values: assert property (@(posedge clk)
    !rst_n |=> (data_out_p == '0 && (&data_out_n) && !frame_out && !underflow && !loaden))
    else $error("outputs left their reset values during reset");

endmodule

//--- dv/tb_tx_top.sv
// ******************************
// transmit path testbench
// table driven stimulus, lane capture
// into sample words and a scoreboard
// ******************************

`timescale 1ns/100ps

module tb_tx_top;

  import tx_pkg::*;

  localparam int data_width    = 16;
  localparam int serdes_factor = 8;
  localparam int frame_w       = data_width * serdes_factor;
  localparam int n_tests       = 5;

  // ******************************
  // test table
  // ******************************

  string        test_name [n_tests] = '{"data_full", "ramp", "data_sparse", "const", "ramp_again"};
  pattern_sel_t test_sel  [n_tests] = '{pat_data, pat_ramp, pat_data, pat_const, pat_ramp};
  logic [data_width-1:0] test_word [n_tests] = '{16'h0, 16'h0, 16'h0, 16'ha5c3, 16'h0};
  int test_frames  [n_tests] = '{12, 6, 10, 5, 4};
  int test_density [n_tests] = '{100, 100, 40, 100, 100};

  logic                  clk;
  logic                  rst_n;
  logic [data_width-1:0] sample;
  logic                  sample_valid;
  pattern_sel_t          pattern_sel;
  logic [data_width-1:0] pattern_word;
  logic [data_width-1:0] data_out_p;
  logic [data_width-1:0] data_out_n;
  logic                  frame_out;
  logic                  underflow;

  int err_count   = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  int cur_test    = 0;
  logic data_seen = 1'b0;
  // input frames still to come out
  // sample 0 sits in the low word
  logic [frame_w-1:0] ref_q [$];

  tx_top #(
    .data_width    (data_width),
    .serdes_factor (serdes_factor)
  ) tx_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .pattern_sel  (pattern_sel),
    .pattern_word (pattern_word),
    .data_out_p   (data_out_p),
    .data_out_n   (data_out_n),
    .frame_out    (frame_out),
    .underflow    (underflow)
  );

  bind tx_top tx_asserts #(
    .data_width    (data_width),
    .serdes_factor (serdes_factor)
  ) tx_asserts_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .loaden     (pack_frame.loaden),
    .data_out_p (data_out_p),
    .data_out_n (data_out_n),
    .frame_out  (frame_out),
    .underflow  (underflow)
  );

  always #5 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, %0d errors so far", cycle_limit, err_count);
      $display("Finished with errors");
      $finish;
    end
  end

  // ******************************
  // frame capture and scoreboard
  // ******************************

  // select, word and test in force at the load edge
  pattern_sel_t          sel_q;
  logic [data_width-1:0] word_q;
  int                    test_q;
  pattern_sel_t          frame_sel;
  logic [data_width-1:0] frame_word;
  int                    frame_test;
  logic                  frame_uf;
  logic [frame_w-1:0]    rebuilt;
  logic [data_width-1:0] ramp_last;
  logic ramp_valid = 1'b0;
  logic fo_prev    = 1'b0;
  logic capturing  = 1'b0;
  logic seen_rise  = 1'b0;
  int   cap_idx;
  int   period_cnt;
  int   high_cnt;

  always @(posedge clk) begin
    sel_q  <= pattern_sel;
    word_q <= pattern_word;
    test_q <= cur_test;
  end

  task automatic check_frame();
    logic [frame_w-1:0]    exp_frame;
    logic [data_width-1:0] exp_w;
    logic [data_width-1:0] got_w;
    if (frame_sel != pat_data && frame_uf) begin
      err_count++;
      $display("[ERROR] %s underflow: expected 0, actual 1", test_name[frame_test]);
    end
    if (frame_sel == pat_ramp) begin
      // ramp starts at zero out of reset and runs on across frames
      exp_w = ramp_valid ? ramp_last + 1'b1 : '0;
      for (int i = 0; i < serdes_factor; i++) begin
        got_w = rebuilt[i*data_width +: data_width];
        if (got_w !== exp_w) begin
          err_count++;
          $display("[ERROR] %s sample %0d: expected %h, actual %h",
                   test_name[frame_test], i, exp_w, got_w);
        end
        exp_w = got_w + 1'b1;
      end
      ramp_last  = got_w;
      ramp_valid = 1'b1;
    end else if (frame_sel == pat_const) begin
      for (int i = 0; i < serdes_factor; i++) begin
        got_w = rebuilt[i*data_width +: data_width];
        if (got_w !== frame_word) begin
          err_count++;
          $display("[ERROR] %s sample %0d: expected %h, actual %h",
                   test_name[frame_test], i, frame_word, got_w);
        end
      end
    end else if (frame_uf) begin
      if (rebuilt !== '0) begin
        err_count++;
        $display("[ERROR] %s idle frame: expected 0, actual %h", test_name[frame_test], rebuilt);
      end
      // at full rate a frame is always waiting once the stream runs
      if (test_density[frame_test] == 100 && data_seen && ref_q.size() != 0) begin
        err_count++;
        $display("%s: underflow while input frames were waiting", test_name[frame_test]);
      end
    end else if (ref_q.size() == 0) begin
      err_count++;
      $display("%s: data frame sent with no input frame behind it", test_name[frame_test]);
    end else begin
      exp_frame = ref_q.pop_front();
      data_seen = 1'b1;
      if (rebuilt !== exp_frame) begin
        err_count++;
        $display("[ERROR] %s data frame: expected %h, actual %h",
                 test_name[frame_test], exp_frame, rebuilt);
      end
    end
  endtask

  // lanes are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (data_out_n !== ~data_out_p) begin
        err_count++;
        $display("[ERROR] %s data_out_n: expected %h, actual %h",
                 test_name[test_q], ~data_out_p, data_out_n);
      end
      if (frame_out && !fo_prev) begin
        // frame clock period and high time of the frame just ended
        if (seen_rise && (period_cnt != serdes_factor || high_cnt != serdes_factor / 2)) begin
          err_count++;
          $display("[ERROR] %s frame clock: expected %0d/%0d, actual %0d/%0d",
                   test_name[test_q], serdes_factor / 2, serdes_factor, high_cnt, period_cnt);
        end
        seen_rise  = 1'b1;
        period_cnt = 0;
        high_cnt   = 0;
        cap_idx    = 0;
        capturing  = 1'b1;
        frame_sel  = sel_q;
        frame_word = word_q;
        frame_test = test_q;
        frame_uf   = underflow;
      end
      period_cnt++;
      if (frame_out) begin
        high_cnt++;
      end
      // sample i is on the lanes i cycles into the frame
      if (capturing) begin
        rebuilt[cap_idx*data_width +: data_width] = data_out_p;
        cap_idx++;
        if (cap_idx == serdes_factor) begin
          capturing = 1'b0;
          check_frame();
        end
      end
      fo_prev = frame_out;
    end
  end

  // ******************************
  // stimulus
  // ******************************

  initial begin
    logic [frame_w-1:0] cur_frame;
    int                 widx;
    int                 fed;
    void'($urandom(32'h1e57e5aa));
    clk          = 1'b0;
    rst_n        = 1'b0;
    sample       = '0;
    sample_valid = 1'b0;
    pattern_sel  = pat_data;
    pattern_word = '0;
    cycle_limit  = 200;
    for (int t = 0; t < n_tests; t++) begin
      cycle_limit += test_frames[t] * serdes_factor * 4;
    end
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int t = 0; t < n_tests; t++) begin
      // switch source right after a frame has loaded
      @(posedge frame_out);
      #1;
      cur_test     = t;
      pattern_sel  = test_sel[t];
      pattern_word = test_word[t];
      data_seen    = 1'b0;
      if (test_sel[t] == pat_data) begin
        widx = 0;
        fed  = 0;
        while (fed < test_frames[t]) begin
          sample_valid = ($urandom_range(99) < test_density[t]);
          if (sample_valid) begin
            sample = data_width'($urandom);
            cur_frame[widx*data_width +: data_width] = sample;
            widx++;
            if (widx == serdes_factor) begin
              ref_q.push_back(cur_frame);
              widx = 0;
              fed++;
            end
          end
          @(posedge clk);
          #1;
        end
        sample_valid = 1'b0;
        // every input frame has to come out before the next test
        while (ref_q.size() != 0) begin
          @(posedge clk);
        end
      end else begin
        repeat (test_frames[t]) @(posedge frame_out);
      end
    end
    repeat (2) @(posedge frame_out);
    @(negedge clk);
    #1;
    $display("run complete, %0d errors", err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- vlog.f
common/tx_pkg.sv
common/tx_frame_if.sv
rtl/sample_packer.sv
rtl/tx_pattern_gen.sv
serdes_out/serdes_out_core.sv
serdes_out/serdes_out.sv
rtl/tx_top.sv
dv/tx_asserts.sv
dv/tb_tx_top.sv
